// ==== list.f ====
design/shift_pkg.sv
design/frame_ctrl.sv
design/beat_counter.sv
design/shift_in_stage.sv
design/shift_out_stage.sv
design/frame_shift_stream.sv
test/frame_shift_checker.sv
test/frame_shift_stream_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the frame shift stream testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -j 0 --top-module frame_shift_stream_tb \
    -f list.f -o frame_shift_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/frame_shift_sim > sim.log 2>&1 \
    || echo "Simulation exited with an error status, see sim.log"
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log && { echo "PASS"; exit 0; } \
    || { echo "FAIL: no result line in sim.log"; exit 1; }

// ==== test/frame_shift_stream_tb.sv ====
// Testbench top for the frame shift stream; seeded random frames with back-pressure
`timescale 1ns/1ps

module frame_shift_stream_tb;

    import shift_pkg::*;

    localparam int          CLK_HALF     = 2;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_FRAMES   = 200;
    localparam int          NUM_SAMPLES  = NUM_FRAMES * FRAME_LEN;
    // Roughly 2.5 cycles per sample at the drawn rates, kept well above that
    localparam int          TIMEOUT_CYCLES = NUM_SAMPLES * 12 + 800;
    localparam logic [31:0] RAND_SEED    = 32'h98d5a2f0;

    logic    aclk;
    logic    aresetn;
    sample_t s_tdata;
    shift_t  s_tuser_shift;
    logic    s_tuser_sign;
    logic    s_tvalid;
    logic    s_tready;
    sample_t m_tdata;
    logic    m_tlast;
    logic    m_tvalid;
    logic    m_tready;

    int      sent;
    logic    accepted;
    int      cycles = 0;
    int      extra_errors;
    int      total_errors;
    string   summary;

    int      out_count;
    int      pending;
    int      err_logical;
    int      err_sign;
    int      err_settings;
    int      err_framing;
    int      err_backpressure;
    int      err_reset;

    frame_shift_stream frame_shift_stream_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_tdata       (s_tdata),
        .s_tuser_shift (s_tuser_shift),
        .s_tuser_sign  (s_tuser_sign),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .m_tdata       (m_tdata),
        .m_tlast       (m_tlast),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready)
    );

    frame_shift_checker frame_shift_checker_i (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .s_tdata          (s_tdata),
        .s_tuser_shift    (s_tuser_shift),
        .s_tuser_sign     (s_tuser_sign),
        .s_tvalid         (s_tvalid),
        .s_tready         (s_tready),
        .m_tdata          (m_tdata),
        .m_tlast          (m_tlast),
        .m_tvalid         (m_tvalid),
        .m_tready         (m_tready),
        .out_count        (out_count),
        .pending          (pending),
        .err_logical      (err_logical),
        .err_sign         (err_sign),
        .err_settings     (err_settings),
        .err_framing      (err_framing),
        .err_backpressure (err_backpressure),
        .err_reset        (err_reset)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #CLK_HALF aclk = ~aclk;
        end
    end

    // Source and sink; new values on falling edges
    initial begin
        void'($urandom(RAND_SEED));
        aresetn       = 1'b0;
        s_tdata       = '0;
        s_tuser_shift = '0;
        s_tuser_sign  = 1'b0;
        s_tvalid      = 1'b0;
        m_tready      = 1'b0;
        sent          = 0;
        accepted      = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        forever begin
            @(negedge aclk);
            m_tready = ($urandom % 10) < 7;
            // A pending sample stays on the bus until taken
            if (!s_tvalid || accepted) begin
                if (sent < NUM_SAMPLES) begin
                    s_tvalid      = ($urandom % 10) < 6;
                    s_tdata       = sample_t'($urandom);
                    s_tuser_shift = shift_t'($urandom);
                    s_tuser_sign  = 1'($urandom);
                end else begin
                    s_tvalid = 1'b0;
                end
            end
            // Handshake for the next rising edge, read once it has settled
            #1;
            accepted = s_tvalid && s_tready;
            if (accepted) begin
                sent++;
            end
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d samples out",
                     cycles, out_count, NUM_SAMPLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        extra_errors = 0;
        @(posedge aresetn);
        while (out_count < NUM_SAMPLES) begin
            @(posedge aclk);
        end
        // Room for a stray extra beat to reach the checker
        repeat (2 * FRAME_LEN) @(posedge aclk);
        if (pending != 0) begin
            $display("%0d accepted samples never reached the output", pending);
            extra_errors++;
        end
        if (sent != NUM_SAMPLES) begin
            $display("Only %0d of %0d samples were accepted", sent, NUM_SAMPLES);
            extra_errors++;
        end
        total_errors = err_logical + err_sign + err_settings + err_framing
                     + err_backpressure + err_reset + extra_errors;
        summary = $sformatf("errors: logical_shift=%0d sign_extend=%0d frame_settings=%0d",
                            err_logical, err_sign, err_settings);
        summary = {summary, $sformatf(" framing=%0d back_pressure=%0d reset=%0d",
                                      err_framing, err_backpressure, err_reset)};
        summary = {summary, $sformatf(" other=%0d total=%0d", extra_errors, total_errors)};
        $display("%s", summary);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== test/frame_shift_checker.sv ====
// Testbench checker; watches the stream ports, models framing and shift, and compares outputs
`timescale 1ns/1ps

module frame_shift_checker (
    input  logic               aclk,
    input  logic               aresetn,
    input  shift_pkg::sample_t s_tdata,
    input  shift_pkg::shift_t  s_tuser_shift,
    input  logic               s_tuser_sign,
    input  logic               s_tvalid,
    input  logic               s_tready,
    input  shift_pkg::sample_t m_tdata,
    input  logic               m_tlast,
    input  logic               m_tvalid,
    input  logic               m_tready,
    output int                 out_count,
    output int                 pending,
    output int                 err_logical,
    output int                 err_sign,
    output int                 err_settings,
    output int                 err_framing,
    output int                 err_backpressure,
    output int                 err_reset
);

    import shift_pkg::*;

    // Expected results, oldest first
    sample_t exp_data_q[$];
    logic    exp_sign_q[$];
    // Same sample shifted with its own side-band, to spot a wrong settings source
    sample_t own_data_q[$];

    int      n_out = 0;
    int      n_pending = 0;
    int      n_logical = 0;
    int      n_sign = 0;
    int      n_settings = 0;
    int      n_framing = 0;
    int      n_backpressure = 0;
    int      n_reset = 0;

    int      in_count;
    shift_t  cur_shift;
    logic    cur_sign;
    logic    after_reset;
    logic    was_stalled;
    sample_t stalled_data;
    logic    stalled_last;
    sample_t exp_data;
    sample_t own_data;
    logic    exp_sign;
    logic    exp_last;
    logic    exp_ready;
    string   test_name;

    assign out_count        = n_out;
    assign pending          = n_pending;
    assign err_logical      = n_logical;
    assign err_sign         = n_sign;
    assign err_settings     = n_settings;
    assign err_framing      = n_framing;
    assign err_backpressure = n_backpressure;
    assign err_reset        = n_reset;

    // Right shift; bits shifted in from above take the fill
    function automatic sample_t shift_model(sample_t d, shift_t sh, logic sgn);
        sample_t r;
        int      src;
        for (int i = 0; i < DATA_W; i++) begin
            src = i + int'(sh);
            if (src < DATA_W) begin
                r[i] = d[src];
            end else begin
                r[i] = sgn ? d[DATA_W-1] : 1'b0;
            end
        end
        return r;
    endfunction

    always @(posedge aclk) begin
        if (!aresetn) begin
            if (m_tvalid) begin
                $display("error reset: expected 0 actual 1 on m_tvalid during reset");
                n_reset++;
            end
            exp_data_q.delete();
            exp_sign_q.delete();
            own_data_q.delete();
            in_count    = 0;
            n_out       = 0;
            after_reset = 1'b1;
            was_stalled = 1'b0;
        end else begin
            if (after_reset && m_tvalid) begin
                $display("error reset: expected 0 actual 1 on m_tvalid after reset");
                n_reset++;
            end
            after_reset = 1'b0;

            // Input side stalls only with both stages holding a sample and the sink stalled
            exp_ready = (exp_data_q.size() < 2) || m_tready;
            if (s_tready !== exp_ready) begin
                $display("error back_pressure: expected s_tready %b actual %b",
                         exp_ready, s_tready);
                n_backpressure++;
            end

            // Held beat must not move or vanish while the sink stalls
            if (was_stalled) begin
                if (!m_tvalid) begin
                    $display("error back_pressure: m_tvalid dropped before the sink took the beat");
                    n_backpressure++;
                end else if (m_tdata !== stalled_data || m_tlast !== stalled_last) begin
                    $display("error back_pressure: expected %h actual %h",
                             {stalled_last, stalled_data}, {m_tlast, m_tdata});
                    n_backpressure++;
                end
            end
            was_stalled  = m_tvalid && !m_tready;
            stalled_data = m_tdata;
            stalled_last = m_tlast;

            if (s_tvalid && s_tready) begin
                // First sample of a frame sets shift and sign for all eight
                if (in_count % FRAME_LEN == 0) begin
                    cur_shift = s_tuser_shift;
                    cur_sign  = s_tuser_sign;
                end
                exp_data_q.push_back(shift_model(s_tdata, cur_shift, cur_sign));
                exp_sign_q.push_back(cur_sign);
                own_data_q.push_back(shift_model(s_tdata, s_tuser_shift, s_tuser_sign));
                in_count++;
            end

            if (m_tvalid && m_tready) begin
                if (exp_data_q.size() == 0) begin
                    $display("error back_pressure: output transfer with no input sample left");
                    n_backpressure++;
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_sign = exp_sign_q.pop_front();
                    own_data = own_data_q.pop_front();
                    if (m_tdata !== exp_data) begin
                        if (m_tdata === own_data) begin
                            test_name = "frame_settings";
                            n_settings++;
                        end else if (exp_sign) begin
                            test_name = "sign_extend";
                            n_sign++;
                        end else begin
                            test_name = "logical_shift";
                            n_logical++;
                        end
                        $display("error %s: expected %h actual %h",
                                 test_name, exp_data, m_tdata);
                    end
                end
                // Every eighth output transfer closes a frame
                exp_last = (n_out % FRAME_LEN == FRAME_LEN - 1);
                if (m_tlast !== exp_last) begin
                    $display("error framing: expected %b actual %b", exp_last, m_tlast);
                    n_framing++;
                end
                n_out++;
            end
        end
        n_pending = exp_data_q.size();
    end

endmodule

// ==== design/frame_shift_stream.sv ====
// Top level of the framed right-shift stream; controller, counter and two register stages
`timescale 1ns/1ps

module frame_shift_stream (
    input  logic              aclk,
    input  logic              aresetn,
    input  shift_pkg::sample_t s_tdata,
    input  shift_pkg::shift_t  s_tuser_shift,
    input  logic              s_tuser_sign,
    input  logic              s_tvalid,
    output logic              s_tready,
    output shift_pkg::sample_t m_tdata,
    output logic              m_tlast,
    output logic              m_tvalid,
    input  logic              m_tready
);

    import shift_pkg::*;

    // Frame tracking
    logic in_accept;
    logic last_beat;
    logic load_settings;
    logic mark_last;

    // Between the two register stages
    logic    mid_valid;
    sample_t mid_data;
    shift_t  mid_shift;
    logic    mid_sign;
    logic    mid_last;
    logic    mid_ready;

    frame_ctrl frame_ctrl_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .in_accept     (in_accept),
        .last_beat     (last_beat),
        .load_settings (load_settings),
        .mark_last     (mark_last)
    );

    beat_counter beat_counter_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_accept (in_accept),
        .last_beat (last_beat)
    );

    shift_in_stage shift_in_stage_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_tdata       (s_tdata),
        .s_tuser_shift (s_tuser_shift),
        .s_tuser_sign  (s_tuser_sign),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .load_settings (load_settings),
        .mark_last     (mark_last),
        .in_accept     (in_accept),
        .mid_valid     (mid_valid),
        .mid_data      (mid_data),
        .mid_shift     (mid_shift),
        .mid_sign      (mid_sign),
        .mid_last      (mid_last),
        .mid_ready     (mid_ready)
    );

    shift_out_stage shift_out_stage_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .mid_valid (mid_valid),
        .mid_data  (mid_data),
        .mid_shift (mid_shift),
        .mid_sign  (mid_sign),
        .mid_last  (mid_last),
        .mid_ready (mid_ready),
        .m_tdata   (m_tdata),
        .m_tlast   (m_tlast),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready)
    );

endmodule

// ==== design/shift_out_stage.sv ====
// Output register stage; right shift with zero or sign fill toward the master port
`timescale 1ns/1ps

module shift_out_stage (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              mid_valid,
    input  shift_pkg::sample_t mid_data,
    input  shift_pkg::shift_t  mid_shift,
    input  logic              mid_sign,
    input  logic              mid_last,
    output logic              mid_ready,
    output shift_pkg::sample_t m_tdata,
    output logic              m_tlast,
    output logic              m_tvalid,
    input  logic              m_tready
);

    import shift_pkg::*;

    // One extra top bit carries the fill into the shift
    logic                     fill_bit;
    logic signed [DATA_W:0]   data_ext;
    logic signed [DATA_W:0]   data_shifted;
    sample_t                  shift_result;
    logic                     mid_accept;

    // Sign bit only when sign extension is selected
    assign fill_bit = mid_sign && mid_data[DATA_W-1];
    assign data_ext = {fill_bit, mid_data};

    // Arithmetic shift of the extended word replicates the fill into vacated bits
    assign data_shifted = data_ext >>> mid_shift;
    assign shift_result = data_shifted[DATA_W-1:0];

    // Output register empty or draining this cycle
    assign mid_ready  = !m_tvalid || m_tready;
    assign mid_accept = mid_valid && mid_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
        end else begin
            if (mid_ready) begin
                m_tvalid <= mid_valid;
            end
            if (mid_accept) begin
                m_tlast <= mid_last;
            end
        end
    end

    // Result payload
    always_ff @(posedge aclk) begin
        if (mid_accept) begin
            m_tdata <= shift_result;
        end
    end

    // Master side holds its beat until the sink takes it
    a_out_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast))
    ) else $error("shift_out_stage: output changed while stalled");

    // Vacated bits follow the selected fill
    a_fill_bits: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (mid_accept && mid_shift != '0) |->
            (shift_result[DATA_W-1] == fill_bit)
    ) else $error("shift_out_stage: wrong fill in vacated bits");

endmodule

// ==== design/shift_in_stage.sv ====
// Input register stage; holds the sample, frame settings and last tag, drives s_tready
`timescale 1ns/1ps

module shift_in_stage (
    input  logic              aclk,
    input  logic              aresetn,
    input  shift_pkg::sample_t s_tdata,
    input  shift_pkg::shift_t  s_tuser_shift,
    input  logic              s_tuser_sign,
    input  logic              s_tvalid,
    output logic              s_tready,
    input  logic              load_settings,
    input  logic              mark_last,
    output logic              in_accept,
    output logic              mid_valid,
    output shift_pkg::sample_t mid_data,
    output shift_pkg::shift_t  mid_shift,
    output logic              mid_sign,
    output logic              mid_last,
    input  logic              mid_ready
);

    import shift_pkg::*;

    // Settings captured from the first sample of the current frame
    shift_t frame_shift;
    logic   frame_sign;

    // Settings that travel with this sample
    shift_t beat_shift;
    logic   beat_sign;

    // Empty, or the held sample moves on this cycle
    assign s_tready  = !mid_valid || mid_ready;
    assign in_accept = s_tvalid && s_tready;

    // First sample uses the port side-band directly, later ones the held copy
    assign beat_shift = load_settings ? s_tuser_shift : frame_shift;
    assign beat_sign  = load_settings ? s_tuser_sign : frame_sign;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mid_valid <= 1'b0;
        end else if (s_tready) begin
            mid_valid <= s_tvalid;
        end
    end

    // Sample payload
    always_ff @(posedge aclk) begin
        if (in_accept) begin
            mid_data  <= s_tdata;
            mid_shift <= beat_shift;
            mid_sign  <= beat_sign;
            mid_last  <= mark_last;
        end
    end

    // Frame settings, loaded once per frame
    always_ff @(posedge aclk) begin
        if (load_settings) begin
            frame_shift <= s_tuser_shift;
            frame_sign  <= s_tuser_sign;
        end
    end

    // A load always comes with an accepted sample
    a_load_on_accept: assert property (
        @(posedge aclk) disable iff (!aresetn)
        load_settings |-> in_accept
    ) else $error("shift_in_stage: settings load without a transfer");

    // Held sample does not change while stalled toward the output stage
    a_mid_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (mid_valid && !mid_ready) |=> (mid_valid && $stable(mid_data) && $stable(mid_last))
    ) else $error("shift_in_stage: held sample changed under back-pressure");

endmodule

// ==== design/beat_counter.sv ====
// Counts accepted samples within a frame and flags the final position
`timescale 1ns/1ps

module beat_counter (
    input  logic aclk,
    input  logic aresetn,
    input  logic in_accept,
    output logic last_beat
);

    import shift_pkg::*;

    beat_cnt_t count;

    // Final position of the frame
    assign last_beat = (count == beat_cnt_t'(FRAME_LEN - 1));

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else if (in_accept) begin
            if (last_beat) begin
                count <= '0;
            end else begin
                count <= count + beat_cnt_t'(1);
            end
        end
    end

    // Count stays inside the frame
    a_count_range: assert property (
        @(posedge aclk) disable iff (!aresetn)
        count <= beat_cnt_t'(FRAME_LEN - 1)
    ) else $error("beat_counter: count beyond frame length");

endmodule

// ==== design/frame_ctrl.sv ====
// Frame boundary FSM; loads frame settings on the first sample and tags the last one
`timescale 1ns/1ps

module frame_ctrl (
    input  logic aclk,
    input  logic aresetn,
    input  logic in_accept,
    input  logic last_beat,
    output logic load_settings,
    output logic mark_last
);

    import shift_pkg::*;

    frame_state_t state;
    frame_state_t state_next;

    // Next state decode
    always_comb begin
        state_next = state;
        case (state)
            FRAME_IDLE: begin
                if (in_accept) begin
                    state_next = FRAME_BODY;
                end
            end
            FRAME_BODY: begin
                // Frames are never one sample long, so the last beat is always in the body
                if (in_accept && last_beat) begin
                    state_next = FRAME_IDLE;
                end
            end
            default: begin
                state_next = FRAME_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= FRAME_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // First accepted sample of a frame brings the side-band
    assign load_settings = in_accept && (state == FRAME_IDLE);

    // Final accepted sample of a frame
    assign mark_last = in_accept && last_beat;

    // Counter and FSM stay aligned; no last beat while waiting for a frame
    a_idle_not_last: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (state == FRAME_IDLE) |-> !last_beat
    ) else $error("frame_ctrl: beat counter at last position while idle");

    // Body never sees a second settings load before the frame closes
    a_no_load_in_body: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (state == FRAME_BODY) |-> !load_settings
    ) else $error("frame_ctrl: settings load inside a frame body");

endmodule

// ==== design/shift_pkg.sv ====
// Shared widths, frame length, vector types and frame FSM states for the frame shift stream
package shift_pkg;

    // Sample and shift amount widths
    localparam int DATA_W  = 16;
    localparam int SHIFT_W = 4;

    // Fixed frame of eight samples, counted with three bits
    localparam int FRAME_LEN = 8;
    localparam int CNT_W     = 3;

    // One sample on either side of the stream
    typedef logic [DATA_W-1:0] sample_t;

    // Right shift amount from the user side-band
    typedef logic [SHIFT_W-1:0] shift_t;

    // Position of a sample inside its frame
    typedef logic [CNT_W-1:0] beat_cnt_t;

    // Frame tracking FSM
    typedef enum logic [0:0] {
        FRAME_IDLE = 1'b0,  // waiting for the first sample
        FRAME_BODY = 1'b1   // inside a frame
    } frame_state_t;

endpackage
